//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_bitmove
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- compile.f
source/bitmove_pkg.sv
source/bitmove_regs.sv
source/word_fifo.sv
source/bit_reader.sv
source/bit_aligner.sv
source/bit_writer.sv
source/mem_arbiter.sv
source/bitmove_top.sv
testbench/bitmove_checker.sv
testbench/tb_bitmove.sv

//--- source/bit_aligner.sv
`timescale 1ns/100ps

module bit_aligner #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          start,
    input  bitmove_pkg::bit_addr_t        src_addr,
    input  logic [bitmove_pkg::LEN_W-1:0] length,
    input  bitmove_pkg::word_t            in_head,
    input  logic                          in_valid,
    input  logic                          credit,
    output logic                          in_pop,
    output logic                          push,
    output bitmove_pkg::chunk_t           push_data
);
    import bitmove_pkg::*;

    localparam int CRD_W = $clog2(FIFO_DEPTH + 1);

    logic [OFS_W-1:0]    ofs;
    logic [LEN_W-1:0]    bits_left;
    logic [CRD_W-1:0]    credits;
    logic                have_cur;
    word_t               cur;
    logic                need_next;
    logic                load;
    logic [2*WORD_W-1:0] pair;

    // The chunk reaches into the next source word
    assign need_next = ({1'b0, bits_left} + (LEN_W + 1)'(ofs)) > (LEN_W + 1)'(WORD_W);

    assign load   = !have_cur && in_valid && (bits_left != '0);
    assign push   = have_cur && (bits_left != '0) && (credits != '0)
                 && (in_valid || !need_next);
    assign in_pop = load || (push && need_next);

    // --------------------------------------
    // Chunk extraction
    // --------------------------------------
    assign pair            = {in_head, cur} >> ofs;
    assign push_data.data  = pair[WORD_W-1:0];
    assign push_data.nbits = (bits_left >= LEN_W'(WORD_W)) ? 6'(WORD_W) : bits_left[5:0];

    always_ff @(posedge clk) begin
        if (start) begin
            ofs <= src_addr[OFS_W-1:0];
        end
        if (in_pop) begin
            cur <= in_head;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bits_left <= '0;
            credits   <= '0;
            have_cur  <= 1'b0;
        end else if (start) begin
            bits_left <= length;
            credits   <= CRD_W'(FIFO_DEPTH);
            have_cur  <= 1'b0;
        end else begin
            if (load) begin
                have_cur <= 1'b1;
            end
            if (push) begin
                bits_left <= (bits_left > LEN_W'(WORD_W)) ? bits_left - LEN_W'(WORD_W) : '0;
            end
            credits <= credits - CRD_W'(push) + CRD_W'(credit);
        end
    end

endmodule

//--- source/bit_reader.sv
`timescale 1ns/100ps

module bit_reader #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           start,
    input  bitmove_pkg::bit_addr_t         src_addr,
    input  logic [bitmove_pkg::LEN_W-1:0]  length,
    input  logic                           gnt,
    input  logic                           rdata_valid,
    input  bitmove_pkg::word_t             rdata,
    input  logic                           credit,
    output logic                           req,
    output logic [bitmove_pkg::ADDR_W-1:0] addr,
    output logic                           push,
    output bitmove_pkg::word_t             push_data
);
    import bitmove_pkg::*;

    localparam int CRD_W = $clog2(FIFO_DEPTH + 1);

    logic [LEN_W-1:0] words_left;
    logic [CRD_W-1:0] credits;
    logic [LEN_W:0]   span;

    // Source bits touched, rounded up to whole words
    assign span = {1'b0, length} + (LEN_W + 1)'(src_addr[OFS_W-1:0])
                + (LEN_W + 1)'(WORD_W - 1);

    assign req       = (words_left != '0) && (credits != '0);
    assign push      = rdata_valid;
    assign push_data = rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            words_left <= '0;
            credits    <= '0;
            addr       <= '0;
        end else if (start) begin
            words_left <= LEN_W'(span[LEN_W:OFS_W]);
            credits    <= CRD_W'(FIFO_DEPTH);
            addr       <= src_addr[ADDR_W+OFS_W-1:OFS_W];
        end else begin
            if (gnt) begin
                words_left <= words_left - 1'b1;
                addr       <= addr + 1'b1;
            end
            credits <= credits - CRD_W'(gnt) + CRD_W'(credit);
        end
    end

endmodule

//--- source/bit_writer.sv
`timescale 1ns/100ps

module bit_writer (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           start,
    input  bitmove_pkg::bit_addr_t         dst_addr,
    input  logic [bitmove_pkg::LEN_W-1:0]  length,
    input  bitmove_pkg::chunk_t            chunk,
    input  logic                           chunk_valid,
    input  logic                           gnt,
    input  logic                           rdata_valid,
    input  bitmove_pkg::word_t             rdata,
    output logic                           chunk_pop,
    output logic                           req,
    output logic                           we,
    output logic [bitmove_pkg::ADDR_W-1:0] addr,
    output bitmove_pkg::word_t             wdata,
    output logic                           move_end
);
    import bitmove_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_FILL, S_WAIT, S_MERGE} state_t;

    state_t              state;
    logic [2*WORD_W-1:0] acc;
    logic [6:0]          acc_n;
    logic [LEN_W-1:0]    remaining;
    logic [OFS_W-1:0]    dofs;
    logic                first;
    word_t               old_word;
    logic [OFS_W-1:0]    lo;
    logic [5:0]          hi;
    logic [2*WORD_W-1:0] hi_ones;
    logic [2*WORD_W-1:0] keep_ones;
    word_t               mask;
    logic                full;
    logic                word_ready;
    logic                last;
    logic                advance;

    // --------------------------------------
    // Bit mask of the current word
    // --------------------------------------
    assign lo        = first ? dofs : '0;
    assign hi        = (acc_n >= 7'd32) ? 6'd32 : acc_n[5:0];
    assign hi_ones   = ((2*WORD_W)'(1) << hi) - (2*WORD_W)'(1);
    assign keep_ones = ((2*WORD_W)'(1) << acc_n) - (2*WORD_W)'(1);
    assign mask      = hi_ones[WORD_W-1:0] & ~((word_t'(1) << lo) - word_t'(1));
    assign full      = &mask;

    assign word_ready = (state == S_FILL)
                     && ((acc_n >= 7'd32) || (remaining == '0 && acc_n != '0));
    assign last       = (remaining == '0) && (acc_n <= 7'd32);

    assign req      = word_ready || (state == S_MERGE);
    assign we       = (word_ready && full) || (state == S_MERGE);
    assign wdata    = (old_word & ~mask) | (acc[WORD_W-1:0] & mask);
    assign advance  = gnt && we;
    assign move_end = advance && last;

    // Never set together with word_ready
    assign chunk_pop = (state == S_FILL) && chunk_valid && (acc_n < 7'd32)
                    && (remaining != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else if (start) begin
            state <= S_FILL;
        end else begin
            case (state)
                S_FILL: begin
                    if (gnt) begin
                        state <= !full ? S_WAIT : (last ? S_IDLE : S_FILL);
                    end
                end
                S_WAIT: begin
                    if (rdata_valid) begin
                        state <= S_MERGE;
                    end
                end
                S_MERGE: begin
                    if (gnt) begin
                        state <= last ? S_IDLE : S_FILL;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_n     <= '0;
            remaining <= '0;
            first     <= 1'b0;
            addr      <= '0;
        end else if (start) begin
            acc_n     <= 7'(dst_addr[OFS_W-1:0]);
            remaining <= length;
            first     <= 1'b1;
            addr      <= dst_addr[ADDR_W+OFS_W-1:OFS_W];
        end else if (chunk_pop) begin
            acc_n     <= acc_n + 7'(chunk.nbits);
            remaining <= remaining - LEN_W'(chunk.nbits);
        end else if (advance) begin
            acc_n <= (acc_n > 7'd32) ? acc_n - 7'd32 : '0;
            first <= 1'b0;
            addr  <= addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dofs <= dst_addr[OFS_W-1:0];
        end
        // Carry keeps only the bits below acc_n
        if (chunk_pop) begin
            acc <= (acc & keep_ones) | ({{WORD_W{1'b0}}, chunk.data} << acc_n);
        end else if (advance) begin
            acc <= acc >> WORD_W;
        end
        if (state == S_WAIT && rdata_valid) begin
            old_word <= rdata;
        end
    end

endmodule

//--- source/bitmove_pkg.sv
package bitmove_pkg;

    localparam int WORD_W = 32;
    localparam int OFS_W  = 5;
    localparam int LEN_W  = 27;
    localparam int ADDR_W = 27;

    typedef logic [WORD_W-1:0] word_t;

    // Upper ADDR_W bits select the word, low OFS_W bits the bit in it
    typedef logic [ADDR_W+OFS_W-1:0] bit_addr_t;

    // Bits in copy order from bit 0, nbits in 1..32
    typedef struct packed {
        word_t      data;
        logic [5:0] nbits;
    } chunk_t;

    typedef logic [1:0] reg_addr_t;

    localparam reg_addr_t REG_SRC  = 2'd0;
    localparam reg_addr_t REG_DST  = 2'd1;
    localparam reg_addr_t REG_LEN  = 2'd2;
    localparam reg_addr_t REG_CTRL = 2'd3;

endpackage

//--- source/bitmove_regs.sv
`timescale 1ns/100ps

module bitmove_regs (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          reg_sel,
    input  logic                          reg_write,
    input  bitmove_pkg::reg_addr_t        reg_addr,
    input  bitmove_pkg::word_t            reg_wdata,
    input  logic                          move_end,
    output bitmove_pkg::word_t            reg_rdata,
    output bitmove_pkg::bit_addr_t        src_addr,
    output bitmove_pkg::bit_addr_t        dst_addr,
    output logic [bitmove_pkg::LEN_W-1:0] length,
    output logic                          start,
    output logic                          busy,
    output logic                          done
);
    import bitmove_pkg::*;

    logic wr_en;
    logic go;

    // Register file is locked while a move runs
    assign wr_en = reg_sel && reg_write && !busy;
    assign go    = wr_en && (reg_addr == REG_CTRL) && reg_wdata[0];

    always_ff @(posedge clk) begin
        if (wr_en && reg_addr == REG_SRC) begin
            src_addr <= reg_wdata;
        end
        if (wr_en && reg_addr == REG_DST) begin
            dst_addr <= reg_wdata;
        end
        if (wr_en && reg_addr == REG_LEN) begin
            length <= reg_wdata[LEN_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= go;
            done  <= move_end;
            if (go) begin
                busy <= 1'b1;
            end else if (move_end) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            REG_SRC: reg_rdata = src_addr;
            REG_DST: reg_rdata = dst_addr;
            REG_LEN: reg_rdata = word_t'(length);
            default: reg_rdata = word_t'(busy);
        endcase
    end

endmodule

//--- source/bitmove_top.sv
`timescale 1ns/100ps

module bitmove_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           reg_sel,
    input  logic                           reg_write,
    input  bitmove_pkg::reg_addr_t         reg_addr,
    input  bitmove_pkg::word_t             reg_wdata,
    output bitmove_pkg::word_t             reg_rdata,
    output logic                           done,
    output logic                           mem_req,
    output logic                           mem_we,
    output logic [bitmove_pkg::ADDR_W-1:0] mem_addr,
    output bitmove_pkg::word_t             mem_wdata,
    input  logic                           mem_hold,
    input  bitmove_pkg::word_t             mem_rdata
);
    import bitmove_pkg::*;

    bit_addr_t         src_addr;
    bit_addr_t         dst_addr;
    logic [LEN_W-1:0]  length;
    logic              start;
    logic              busy;
    logic              move_end;
    word_t             rdata;

    logic              rd_req;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_gnt;
    logic              rd_rvalid;
    logic              rq_push;
    word_t             rq_push_data;
    word_t             rq_head;
    logic              rq_valid;
    logic              rq_pop;
    logic              rq_credit;

    logic              ch_push;
    chunk_t            ch_push_data;
    chunk_t            ch_head;
    logic              ch_valid;
    logic              ch_pop;
    logic              ch_credit;

    logic              wr_req;
    logic              wr_we;
    logic [ADDR_W-1:0] wr_addr;
    word_t             wr_wdata;
    logic              wr_gnt;
    logic              wr_rvalid;

    bitmove_regs u_regs (
        .clk, .arst_n, .reg_sel, .reg_write, .reg_addr, .reg_wdata, .move_end,
        .reg_rdata, .src_addr, .dst_addr, .length, .start, .busy, .done
    );

    // --------------------------------------
    // Read side
    // --------------------------------------
    bit_reader #(.FIFO_DEPTH(FIFO_DEPTH)) u_reader (
        .clk, .arst_n, .start, .src_addr, .length,
        .gnt(rd_gnt), .rdata_valid(rd_rvalid), .rdata, .credit(rq_credit),
        .req(rd_req), .addr(rd_addr), .push(rq_push), .push_data(rq_push_data)
    );

    word_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(word_t)) u_read_q (
        .clk, .arst_n, .push(rq_push), .push_data(rq_push_data), .pop(rq_pop),
        .clear(start), .head(rq_head), .not_empty(rq_valid), .credit(rq_credit)
    );

    bit_aligner #(.FIFO_DEPTH(FIFO_DEPTH)) u_aligner (
        .clk, .arst_n, .start, .src_addr, .length,
        .in_head(rq_head), .in_valid(rq_valid), .credit(ch_credit),
        .in_pop(rq_pop), .push(ch_push), .push_data(ch_push_data)
    );

    word_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(chunk_t)) u_chunk_q (
        .clk, .arst_n, .push(ch_push), .push_data(ch_push_data), .pop(ch_pop),
        .clear(start), .head(ch_head), .not_empty(ch_valid), .credit(ch_credit)
    );

    // --------------------------------------
    // Write side and bus
    // --------------------------------------
    bit_writer u_writer (
        .clk, .arst_n, .start, .dst_addr, .length,
        .chunk(ch_head), .chunk_valid(ch_valid), .gnt(wr_gnt),
        .rdata_valid(wr_rvalid), .rdata, .chunk_pop(ch_pop),
        .req(wr_req), .we(wr_we), .addr(wr_addr), .wdata(wr_wdata), .move_end
    );

    mem_arbiter u_arbiter (
        .clk, .arst_n, .wr_req, .wr_we, .wr_addr, .wr_wdata, .rd_req, .rd_addr,
        .mem_hold, .mem_rdata, .wr_gnt, .rd_gnt, .wr_rvalid, .rd_rvalid, .rdata,
        .mem_req, .mem_we, .mem_addr, .mem_wdata
    );

endmodule

//--- source/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           wr_req,
    input  logic                           wr_we,
    input  logic [bitmove_pkg::ADDR_W-1:0] wr_addr,
    input  bitmove_pkg::word_t             wr_wdata,
    input  logic                           rd_req,
    input  logic [bitmove_pkg::ADDR_W-1:0] rd_addr,
    input  logic                           mem_hold,
    input  bitmove_pkg::word_t             mem_rdata,
    output logic                           wr_gnt,
    output logic                           rd_gnt,
    output logic                           wr_rvalid,
    output logic                           rd_rvalid,
    output bitmove_pkg::word_t             rdata,
    output logic                           mem_req,
    output logic                           mem_we,
    output logic [bitmove_pkg::ADDR_W-1:0] mem_addr,
    output bitmove_pkg::word_t             mem_wdata
);
    logic locked;
    logic lock_wr;
    logic sel_wr;
    logic pend;
    logic pend_wr;

    // Writer wins unless a stalled reader request must stay on the bus
    assign sel_wr = locked ? lock_wr : wr_req;

    assign mem_req   = sel_wr ? wr_req : rd_req;
    assign mem_we    = sel_wr && wr_we;
    assign mem_addr  = sel_wr ? wr_addr : rd_addr;
    assign mem_wdata = wr_wdata;

    assign wr_gnt = sel_wr && wr_req && !mem_hold;
    assign rd_gnt = !sel_wr && rd_req && !mem_hold;

    // Read data belongs to whoever issued the pending read
    assign wr_rvalid = pend && pend_wr && !mem_hold;
    assign rd_rvalid = pend && !pend_wr && !mem_hold;
    assign rdata     = mem_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            locked  <= 1'b0;
            lock_wr <= 1'b0;
            pend    <= 1'b0;
            pend_wr <= 1'b0;
        end else begin
            locked  <= mem_req && mem_hold;
            lock_wr <= sel_wr;
            if (!mem_hold) begin
                pend    <= mem_req && !mem_we;
                pend_wr <= sel_wr;
            end
        end
    end

endmodule

//--- source/word_fifo.sv
`timescale 1ns/100ps

module word_fifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type payload_t  = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    input  logic     clear,
    output payload_t head,
    output logic     not_empty,
    output logic     credit
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    payload_t         slots [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);
    assign head      = slots[rd_ptr];
    // Each pop frees one slot for the producer
    assign credit    = do_pop;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(do_pop);
        end
    end

endmodule

//--- testbench/bitmove_checker.sv
`timescale 1ns/100ps

module bitmove_checker (
    input logic                           clk,
    input logic                           arst_n,
    input logic                           done,
    input logic                           busy,
    input logic                           mem_req,
    input logic                           mem_we,
    input logic                           mem_hold,
    input logic [bitmove_pkg::ADDR_W-1:0] mem_addr,
    input bitmove_pkg::word_t             mem_wdata
);
    int assert_errors = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
    else begin
        $error("done stayed high for more than one cycle");
        assert_errors++;
    end

    done_with_busy: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(done) |-> $fell(busy))
    else begin
        $error("busy did not fall together with done");
        assert_errors++;
    end

    we_with_req: assert property (@(posedge clk) disable iff (!arst_n)
        mem_we |-> mem_req)
    else begin
        $error("mem_we seen without mem_req");
        assert_errors++;
    end

    // A stalled request must not move
    hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req && mem_hold) |=> mem_req && $stable(mem_we) && $stable(mem_addr)
                                  && (!mem_we || $stable(mem_wdata)))
    else begin
        $error("bus request changed while mem_hold was high");
        assert_errors++;
    end

endmodule

bind bitmove_top bitmove_checker u_checker (
    .clk(clk),
    .arst_n(arst_n),
    .done(done),
    .busy(busy),
    .mem_req(mem_req),
    .mem_we(mem_we),
    .mem_hold(mem_hold),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata)
);

//--- testbench/tb_bitmove.sv
`timescale 1ns/100ps

module tb_bitmove;
    import bitmove_pkg::*;

    localparam int MEM_WORDS = 64;
    localparam int TIMEOUT   = 3000;

    logic              clk;
    logic              arst_n;
    logic              reg_sel;
    logic              reg_write;
    reg_addr_t         reg_addr;
    word_t             reg_wdata;
    word_t             reg_rdata;
    logic              done;
    logic              mem_req;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    word_t             mem_wdata;
    logic              mem_hold;
    word_t             mem_rdata;

    word_t             mem [MEM_WORDS];
    word_t             shadow [MEM_WORDS];
    logic [5:0]        rd_idx;
    logic              hold_en;
    integer            seed;
    integer            hold_seed;
    string             test_name;
    int                cur_src;
    int                cur_dst;
    int                cur_len;
    logic              check_req;
    logic              check_ack;
    word_t             rd_val;

    bitmove_top #(.FIFO_DEPTH(4)) UUT (
        .clk(clk), .arst_n(arst_n),
        .reg_sel(reg_sel), .reg_write(reg_write), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .done(done),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_hold(mem_hold), .mem_rdata(mem_rdata)
    );

    always #4 clk = ~clk;

    // ----------------------------------------
    // Memory model
    // ----------------------------------------
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_idx <= '0;
        end else if (mem_req && !mem_hold) begin
            if (mem_we) begin
                mem[mem_addr[5:0]] <= mem_wdata;
            end else begin
                rd_idx <= mem_addr[5:0];
            end
        end
    end

    // Read data and stalls change on the falling edge
    always @(negedge clk) begin
        mem_rdata = mem[rd_idx];
        mem_hold  = hold_en && (($random(hold_seed) & 3) == 0);
    end

    // ----------------------------------------
    // Checks and reference model
    // ----------------------------------------
    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s", test_name, what);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    endtask

    function automatic logic shadow_bit(input int a);
        return shadow[a / 32][a % 32];
    endfunction

    // Copy of len bits from src to dst, everything else untouched
    function automatic word_t expected_word(input int w, input int src, input int dst,
                                            input int len);
        word_t r;
        int    a;
        for (int b = 0; b < 32; b++) begin
            a = w * 32 + b;
            if (a >= dst && a < dst + len) begin
                r[b] = shadow_bit(src + a - dst);
            end else begin
                r[b] = shadow_bit(a);
            end
        end
        return r;
    endfunction

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("done never rose");
            end
        end while (!done);
    endtask

    always @(posedge clk) begin
        if (check_req && !check_ack) begin
            wait_for_done();
            for (int w = 0; w < MEM_WORDS; w++) begin
                check_value($sformatf("%s word %0d", test_name, w),
                            expected_word(w, cur_src, cur_dst, cur_len), mem[w]);
            end
            check_ack = 1'b1;
        end
    end

    // ----------------------------------------
    // Register port and move control
    // ----------------------------------------
    task automatic write_reg(input reg_addr_t a, input word_t d);
        reg_sel   = 1'b1;
        reg_write = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(negedge clk);
        reg_sel   = 1'b0;
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a, output word_t d);
        reg_sel   = 1'b1;
        reg_write = 1'b0;
        reg_addr  = a;
        @(negedge clk);
        d         = reg_rdata;
        reg_sel   = 1'b0;
    endtask

    task automatic fill_memory();
        word_t v;
        for (int i = 0; i < MEM_WORDS; i++) begin
            v         = $random(seed);
            mem[i]   <= v;
            shadow[i] = v;
        end
    endtask

    task automatic start_move(input string name, input int src, input int dst,
                              input int len, input logic stall);
        test_name = name;
        hold_en   = stall;
        cur_src   = src;
        cur_dst   = dst;
        cur_len   = len;
        fill_memory();
        write_reg(REG_SRC, word_t'(src));
        write_reg(REG_DST, word_t'(dst));
        write_reg(REG_LEN, word_t'(len));
        write_reg(REG_CTRL, 32'd1);
        check_req = 1'b1;
    endtask

    task automatic finish_move();
        int cycles;
        cycles = 0;
        while (!check_ack) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("compare did not complete");
            end
        end
        @(negedge clk);
        check_req = 1'b0;
        check_ack = 1'b0;
        hold_en   = 1'b0;
    endtask

    task automatic run_move(input string name, input int src, input int dst,
                            input int len, input logic stall);
        start_move(name, src, dst, len, stall);
        finish_move();
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    initial begin
        int src;
        int dst;
        int len;
        clk       = 1'b0;
        arst_n    = 1'b0;
        reg_sel   = 1'b0;
        reg_write = 1'b0;
        reg_addr  = REG_SRC;
        reg_wdata = '0;
        mem_hold  = 1'b0;
        mem_rdata = '0;
        hold_en   = 1'b0;
        check_req = 1'b0;
        check_ack = 1'b0;
        seed      = 14;
        hold_seed = seed;
        fill_memory();
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        run_move("aligned", 2 * 32, 36 * 32, 100, 1'b0);
        run_move("src ofs above dst ofs", 3 * 32 + 19, 40 * 32 + 3, 200, 1'b0);
        run_move("src ofs below dst ofs", 5 * 32 + 2, 34 * 32 + 27, 150, 1'b0);
        run_move("short in one word", 7 * 32 + 11, 45 * 32 + 20, 7, 1'b0);

        for (int i = 0; i < 20; i++) begin
            src = ($random(seed) & 32'h7fff_ffff) % 384;
            dst = 32 * 32 + ($random(seed) & 32'h7fff_ffff) % 384;
            len = 1 + ($random(seed) & 32'h7fff_ffff) % 300;
            run_move($sformatf("random %0d", i), src, dst, len, 1'b1);
        end

        // Register readback around a move
        start_move("register port", 32 + 9, 38 * 32 + 30, 260, 1'b0);
        read_reg(REG_CTRL, rd_val);
        check_value("register port busy during move", 32'd1, rd_val);
        finish_move();
        read_reg(REG_CTRL, rd_val);
        check_value("register port busy after done", 32'd0, rd_val);
        read_reg(REG_SRC, rd_val);
        check_value("register port src", 32'd41, rd_val);
        read_reg(REG_DST, rd_val);
        check_value("register port dst", word_t'(38 * 32 + 30), rd_val);
        read_reg(REG_LEN, rd_val);
        check_value("register port len", 32'd260, rd_val);

        repeat (2) @(negedge clk);
        if (UUT.u_checker.assert_errors != 0) begin
            $display("Bus checker reported %0d assertion failures",
                     UUT.u_checker.assert_errors);
            $display("CHECKS FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
